// File: common/spi_frame_pkg.sv
package spi_frame_pkg;

  // One SPI transfer is a fixed number of bits, MSB first on both lines
  localparam int unsigned frame_bits = 8;

  // Two flag bits lead every frame, the rest is payload
  localparam int unsigned data_bits = frame_bits - 2;

  // Raw content of a shift register
  typedef logic [frame_bits-1:0] frame_t;

  // Host to minion frame as it arrives on mosi
  typedef struct packed {
    logic                 val_wrt;  // Host pushes data toward the system
    logic                 val_rd;   // Host asks for a word on the next reply
    logic [data_bits-1:0] data;
  } push_msg_t;

  // Minion to host frame as it leaves on miso
  typedef struct packed {
    logic                 val;  // Data holds a word popped from the system
    logic                 spc;  // Another write would be accepted
    logic [data_bits-1:0] data;
  } pull_msg_t;

endpackage

// File: common/stream_pkg.sv
package stream_pkg;

  // Payload on the recv and send streams matches the frame payload, so a
  // word moves between SPI and the system without packing or splitting
  typedef logic [spi_frame_pkg::data_bits-1:0] word_t;

  // Entries per direction
  // A depth of two lets the host write back to back while the system
  // takes one word out
  localparam int unsigned queue_depth = 2;

endpackage

// File: design/msg_queue.sv
`timescale 1ns/1ps

module msg_queue #(
  parameter int unsigned depth = stream_pkg::queue_depth
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  stream_pkg::word_t      recv_msg,
  input  logic                   recv_val,
  output logic                   recv_rdy,
  output stream_pkg::word_t      send_msg,
  output logic                   send_val,
  input  logic                   send_rdy,
  output logic [$clog2(depth):0] num_free
);

  // A depth of one still needs a one bit pointer
  localparam int unsigned ptr_bits = (depth > 1) ? $clog2(depth) : 1;
  localparam int unsigned cnt_bits = $clog2(depth) + 1;
  localparam logic [ptr_bits-1:0] last_ptr = ptr_bits'(depth - 1);
  localparam logic [cnt_bits-1:0] full_cnt = cnt_bits'(depth);

  stream_pkg::word_t   entries [depth];
  logic [ptr_bits-1:0] wr_ptr;
  logic [ptr_bits-1:0] rd_ptr;
  logic [cnt_bits-1:0] count;
  logic                do_enq;
  logic                do_deq;

  // Pointers wrap at depth, which need not be a power of two
  function automatic logic [ptr_bits-1:0] ptr_step(input logic [ptr_bits-1:0] ptr);
    return (ptr == last_ptr) ? '0 : ptr + 1'b1;
  endfunction

  assign recv_rdy = (count != full_cnt);
  assign send_val = (count != '0);
  assign do_enq   = recv_val & recv_rdy;
  assign do_deq   = send_val & send_rdy;
  assign send_msg = entries[rd_ptr];  // Head of the queue is always visible
  assign num_free = full_cnt - count;

  always_ff @(posedge clk) begin
    if (do_enq) begin
      entries[wr_ptr] <= recv_msg;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_enq) wr_ptr <= ptr_step(wr_ptr);
      if (do_deq) rd_ptr <= ptr_step(rd_ptr);
      // Simultaneous push and pop leave the occupancy unchanged
      case ({do_enq, do_deq})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// File: design/spi_minion_top.sv
`timescale 1ns/1ps

module spi_minion_top (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              cs_n,
  input  logic              sclk,
  input  logic              mosi,
  output logic              miso,
  input  stream_pkg::word_t recv_msg,
  input  logic              recv_val,
  output logic              recv_rdy,
  output stream_pkg::word_t send_msg,
  output logic              send_val,
  input  logic              send_rdy,
  output logic              parity
);

  // Push and pull side of the frame, between shifter and adapter
  logic                     push_en;
  spi_frame_pkg::push_msg_t push_msg;
  logic                     pull_en;
  spi_frame_pkg::pull_msg_t pull_msg;

  spi_shifter u_shifter (
    .clk      (clk),
    .rst_n    (rst_n),
    .cs_n     (cs_n),
    .sclk     (sclk),
    .mosi     (mosi),
    .miso     (miso),
    .push_en  (push_en),
    .push_msg (push_msg),
    .pull_en  (pull_en),
    .pull_msg (pull_msg)
  );

  minion_adapter u_adapter (
    .clk      (clk),
    .rst_n    (rst_n),
    .push_en  (push_en),
    .push_msg (push_msg),
    .pull_en  (pull_en),
    .pull_msg (pull_msg),
    .recv_msg (recv_msg),
    .recv_val (recv_val),
    .recv_rdy (recv_rdy),
    .send_msg (send_msg),
    .send_val (send_val),
    .send_rdy (send_rdy),
    .parity   (parity)
  );

endmodule

// File: filelist.f
common/spi_frame_pkg.sv
common/stream_pkg.sv
design/msg_queue.sv
minion_adapter/minion_adapter.sv
spi_shifter/spi_shifter.sv
design/spi_minion_top.sv
test/spi_minion_tb.sv

// File: minion_adapter/minion_adapter.sv
`timescale 1ns/1ps

module minion_adapter (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     push_en,
  input  spi_frame_pkg::push_msg_t push_msg,
  input  logic                     pull_en,
  output spi_frame_pkg::pull_msg_t pull_msg,
  input  stream_pkg::word_t        recv_msg,
  input  logic                     recv_val,
  output logic                     recv_rdy,
  output stream_pkg::word_t        send_msg,
  output logic                     send_val,
  input  logic                     send_rdy,
  output logic                     parity
);

  logic                                     rd_req;  // val_rd of the last full frame
  stream_pkg::word_t                        cm_q_send_msg;
  logic                                     cm_q_send_val;
  logic                                     cm_q_send_rdy;
  logic [$clog2(stream_pkg::queue_depth):0] mc_q_num_free;
  logic                                     mc_q_recv_val;
  logic                                     mc_q_recv_rdy;
  logic                                     pop;

  // System to host direction
  msg_queue #(.depth(stream_pkg::queue_depth)) cm_q (
    .clk      (clk),
    .rst_n    (rst_n),
    .recv_msg (recv_msg),
    .recv_val (recv_val),
    .recv_rdy (recv_rdy),
    .send_msg (cm_q_send_msg),
    .send_val (cm_q_send_val),
    .send_rdy (cm_q_send_rdy),
    .num_free ()
  );

  // Host to system direction
  msg_queue #(.depth(stream_pkg::queue_depth)) mc_q (
    .clk      (clk),
    .rst_n    (rst_n),
    .recv_msg (push_msg.data),
    .recv_val (mc_q_recv_val),
    .recv_rdy (mc_q_recv_rdy),
    .send_msg (send_msg),
    .send_val (send_val),
    .send_rdy (send_rdy),
    .num_free (mc_q_num_free)
  );

  // The read flag arrives at the end of one frame and is served at the
  // start of the next one
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_req <= 1'b0;
    end else if (push_en) begin
      rd_req <= push_msg.val_rd;
    end else if (pull_en) begin
      rd_req <= 1'b0;  // One request yields at most one pop
    end
  end

  always_comb begin
    mc_q_recv_val = push_en & push_msg.val_wrt;  // Dropped by the queue when full
    cm_q_send_rdy = pull_en & rd_req;
    pop           = cm_q_send_rdy & cm_q_send_val;
    pull_msg.val  = pop;
    // Room must remain even after a write landing in this very cycle
    pull_msg.spc  = mc_q_recv_rdy & (~mc_q_recv_val | (mc_q_num_free > 1));
    pull_msg.data = cm_q_send_msg & {spi_frame_pkg::data_bits{pop}};
  end

  assign parity = (^send_msg) & send_val;  // Odd parity of the outgoing word

endmodule

// File: run_sim.sh
#!/bin/sh
# Compile the RTL and testbench with Verilator, then run the simulation

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module spi_minion_tb -f filelist.f \
  --Mdir obj_dir -o spi_minion_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit $status
fi

./obj_dir/spi_minion_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation ended with status $status"
  exit $status
fi
exit 0

// File: spi_shifter/spi_shifter.sv
`timescale 1ns/1ps

module spi_shifter (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     cs_n,
  input  logic                     sclk,
  input  logic                     mosi,
  output logic                     miso,
  output logic                     push_en,
  output spi_frame_pkg::push_msg_t push_msg,
  output logic                     pull_en,
  input  spi_frame_pkg::pull_msg_t pull_msg
);

  localparam int unsigned cnt_bits = $clog2(spi_frame_pkg::frame_bits);
  localparam logic [cnt_bits-1:0] last_bit = cnt_bits'(spi_frame_pkg::frame_bits - 1);

  typedef enum logic [1:0] {
    idle,
    shifting,
    done
  } state_t;

  state_t                  state;
  logic [2:0]              cs_n_sync;  // Bit 1 is the synchronized pin, bit 2 its last value
  logic [2:0]              sclk_sync;
  logic [1:0]              mosi_sync;
  logic                    cs_fall;
  logic                    cs_rise;
  logic                    sclk_rise;
  logic                    sclk_fall;
  logic [cnt_bits-1:0]     bit_cnt;
  spi_frame_pkg::frame_t   rx_shift;
  spi_frame_pkg::frame_t   tx_shift;

  // Pins start in their idle levels so reset release shows no false edge
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cs_n_sync <= '1;
      sclk_sync <= '0;
      mosi_sync <= '0;
    end else begin
      cs_n_sync <= {cs_n_sync[1:0], cs_n};
      sclk_sync <= {sclk_sync[1:0], sclk};
      mosi_sync <= {mosi_sync[0], mosi};
    end
  end

  assign cs_fall   = cs_n_sync[2] & ~cs_n_sync[1];
  assign cs_rise   = ~cs_n_sync[2] & cs_n_sync[1];
  assign sclk_rise = ~sclk_sync[2] & sclk_sync[1];
  assign sclk_fall = sclk_sync[2] & ~sclk_sync[1];

  // The adapter answers in the same cycle, so the reply is latched on this edge
  assign pull_en  = cs_fall & (state == idle);
  assign push_msg = spi_frame_pkg::push_msg_t'(rx_shift);
  assign miso     = tx_shift[spi_frame_pkg::frame_bits-1];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= idle;
      bit_cnt  <= '0;
      push_en  <= 1'b0;
      tx_shift <= '0;
    end else begin
      push_en <= 1'b0;
      case (state)
        idle: begin
          if (cs_fall) begin
            state    <= shifting;
            bit_cnt  <= '0;
            tx_shift <= pull_msg;
          end
        end
        shifting: begin
          if (cs_rise) begin
            state <= idle;  // Short frame is thrown away
          end else if (sclk_rise) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == last_bit) begin
              push_en <= 1'b1;
              state   <= done;
            end
          end else if (sclk_fall) begin
            // Mode 0 host samples on the rise, so the next bit goes out on the fall
            tx_shift <= {tx_shift[spi_frame_pkg::frame_bits-2:0], 1'b0};
          end
        end
        done: begin
          if (cs_rise) state <= idle;
        end
        default: state <= idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == shifting && sclk_rise && !cs_rise) begin
      rx_shift <= {rx_shift[spi_frame_pkg::frame_bits-2:0], mosi_sync[1]};
    end
  end

endmodule

// File: test/spi_minion_tb.sv
`timescale 1ns/1ps

module spi_minion_tb;

  localparam int max_ops     = 64;
  localparam int half_period = 4;   // Clk cycles per sclk half-period
  localparam int poll_limit  = 50;  // Cycles a stream may take to respond
  localparam logic [7:0] op_frame = 8'h01;
  localparam logic [7:0] op_recv  = 8'h02;
  localparam logic [7:0] op_send  = 8'h03;
  localparam logic [7:0] op_idle  = 8'h04;

  logic              clk;
  logic              rst_n;
  logic              cs_n;
  logic              sclk;
  logic              mosi;
  logic              miso;
  stream_pkg::word_t recv_msg;
  logic              recv_val;
  logic              recv_rdy;
  stream_pkg::word_t send_msg;
  logic              send_val;
  logic              send_rdy;
  logic              parity;

  logic [7:0]  test_mem [0:max_ops*4-1];  // Four bytes per operation
  logic [31:0] lcg_state = 32'ha5078bd1;
  int          cycle_count = 0;
  int          cycle_limit = 1000000;

  spi_minion_top dut (
    .clk      (clk),
    .rst_n    (rst_n),
    .cs_n     (cs_n),
    .sclk     (sclk),
    .mosi     (mosi),
    .miso     (miso),
    .recv_msg (recv_msg),
    .recv_val (recv_val),
    .recv_rdy (recv_rdy),
    .send_msg (send_msg),
    .send_val (send_val),
    .send_rdy (send_rdy),
    .parity   (parity)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("Test failures found");
    $fatal(1, "Simulation stopped on error");
  endtask

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= cycle_limit) begin
      fail_run($sformatf("Timeout after %0d clock cycles", cycle_count));
    end
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // Odd number of ones in the word gives a parity of one
  function automatic logic odd_parity(input stream_pkg::word_t word);
    logic p;
    p = 1'b0;
    for (int i = 0; i < spi_frame_pkg::data_bits; i++) begin
      if (word[i]) p = ~p;
    end
    return p;
  endfunction

  task automatic check_pull(input string name, input spi_frame_pkg::pull_msg_t got,
                            input spi_frame_pkg::pull_msg_t exp);
    if (got !== exp) begin
      fail_run($sformatf("Mismatch %s: got 0x%02h expected 0x%02h", name, got, exp));
    end
  endtask

  task automatic check_word(input string name, input stream_pkg::word_t got,
                            input stream_pkg::word_t exp);
    if (got !== exp) begin
      fail_run($sformatf("Mismatch %s: got 0x%02h expected 0x%02h", name, got, exp));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      fail_run($sformatf("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  // The mode 0 host samples miso just before each rise and changes mosi on each fall
  task automatic spi_transfer(input spi_frame_pkg::frame_t tx_frame,
                              output spi_frame_pkg::pull_msg_t rx_frame);
    spi_frame_pkg::frame_t rx_bits;
    rx_bits = '0;
    cs_n = 1'b0;
    mosi = tx_frame[spi_frame_pkg::frame_bits-1];
    wait_cycles(half_period);
    for (int i = spi_frame_pkg::frame_bits - 1; i >= 0; i--) begin
      rx_bits[i] = miso;
      sclk = 1'b1;
      wait_cycles(half_period);
      sclk = 1'b0;
      if (i > 0) mosi = tx_frame[i-1];
      wait_cycles(half_period);
    end
    cs_n = 1'b1;
    mosi = 1'b0;
    wait_cycles(half_period);  // Gap so the end of frame is seen before the next one
    rx_frame = spi_frame_pkg::pull_msg_t'(rx_bits);
  endtask

  task automatic push_recv(input stream_pkg::word_t word);
    int waited;
    waited = 0;
    while (!recv_rdy && waited < poll_limit) begin
      @(negedge clk);
      waited++;
    end
    if (!recv_rdy) begin
      fail_run("The recv stream never became ready for a new word");
    end
    recv_msg = word;
    recv_val = 1'b1;
    @(negedge clk);
    recv_val = 1'b0;
    recv_msg = '0;
  endtask

  // The head word is checked first, then held back for a random stall
  task automatic expect_send(input stream_pkg::word_t word);
    int waited;
    int stall;
    waited = 0;
    while (!send_val && waited < poll_limit) begin
      @(negedge clk);
      waited++;
    end
    if (!send_val) begin
      fail_run("Send data never appeared on the send stream");
    end
    check_word("send_msg", send_msg, word);
    check_bit("parity", parity, odd_parity(word));
    lcg_state = lcg_next(lcg_state);
    stall = int'(lcg_state >> 28);
    wait_cycles(stall);
    send_rdy = 1'b1;
    @(negedge clk);
    send_rdy = 1'b0;
  endtask

  initial begin
    spi_frame_pkg::pull_msg_t reply;
    int num_ops;
    int num_frames;
    int base;
    cs_n     = 1'b1;
    sclk     = 1'b0;
    mosi     = 1'b0;
    recv_msg = '0;
    recv_val = 1'b0;
    send_rdy = 1'b0;
    rst_n    = 1'b0;
    for (int i = 0; i < max_ops * 4; i++) test_mem[i] = 8'h00;
    $readmemh("test/spi_minion_testdata.hex", test_mem);
    num_ops    = 0;
    num_frames = 0;
    while (num_ops < max_ops && test_mem[num_ops*4] != 8'h00) begin
      if (test_mem[num_ops*4] == op_frame) num_frames++;
      num_ops++;
    end
    if (num_ops == 0) begin
      fail_run("The test data file holds no operations");
    end
    cycle_limit = num_frames * 80 + (num_ops - num_frames) * 20 + 200;
    wait_cycles(3);
    rst_n = 1'b1;
    @(negedge clk);
    check_bit("miso", miso, 1'b0);
    check_bit("recv_rdy", recv_rdy, 1'b1);
    check_bit("send_val", send_val, 1'b0);
    for (int op = 0; op < num_ops; op++) begin
      base = op * 4;
      case (test_mem[base])
        op_frame: begin
          spi_transfer(test_mem[base+1], reply);
          check_pull("pull_msg", reply, spi_frame_pkg::pull_msg_t'(test_mem[base+2]));
        end
        op_recv: push_recv(test_mem[base+3][spi_frame_pkg::data_bits-1:0]);
        op_send: expect_send(test_mem[base+3][spi_frame_pkg::data_bits-1:0]);
        op_idle: begin
          check_bit("send_val", send_val, 1'b0);
          check_bit("parity", parity, 1'b0);  // No word waiting, so parity stays low
        end
        default: fail_run($sformatf("Unknown operation code %0h in the test data", test_mem[base]));
      endcase
    end
    $display("All tests passed!");
    $finish;
  end

endmodule

// File: test/spi_minion_testdata.hex
// Columns: operation, mosi frame, expected miso frame, system-side word
// Operations: 01 SPI frame, 02 push word on recv, 03 expect word on send, 04 send idle
04 00 40 00
01 00 40 00
01 AA 40 00
03 00 00 2A
01 93 40 00
03 00 00 13
02 00 00 15
01 40 40 00
01 00 D5 00
01 40 40 00
01 00 40 00
// Send queue fills while send_rdy is held low
01 81 40 00
01 82 40 00
01 83 00 00
01 00 00 00
03 00 00 01
03 00 00 02
04 00 00 00
// Interleaved writes and reads
02 00 00 21
02 00 00 22
01 C5 40 00
01 C6 E1 00
03 00 00 05
01 47 E2 00
02 00 00 3F
01 88 FF 00
01 89 00 00
03 00 00 06
03 00 00 08
01 8C 40 00
03 00 00 0C
04 00 00 00
